//--- sources.f
hdl/sdram_cfg_pkg.sv
hdl/sdram_cmd_pkg.sv
hdl/sdram_init_seq.sv
hdl/sdram_ctrl.sv
hdl/sdram_top.sv
hdl/sdram_test.sv
tests/sdram_model.sv
tests/tb_sdram_test.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_sdram_test -f sources.f -o tb_sim \
    && out=$(./obj_dir/tb_sim) ; echo "$out" \
    && echo "$out" | grep -q "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tests/tb_sdram_test.sv
`timescale 1ns/1ps

module tb_sdram_test
    import sdram_cfg_pkg::*;
    import sdram_cmd_pkg::*;
;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
        logic [data_w-1:0] pat;
        logic              fault;
        logic [len_w-1:0]  fault_k;  // Word offset that reads back corrupted
        logic [len_w-1:0]  exp_err;
    } row_t;

    localparam int n_rows = 6;
    localparam int limit  = n_rows * (2 * 256 + 64) + int'(t_powerup) + 1000;

    logic              sys_clk;
    logic              reset_n;
    logic              start_n;
    burst_req_t        test_cfg;
    logic [data_w-1:0] pattern_base;
    logic              busy;
    logic              done;
    logic [len_w-1:0]  err_count;
    logic              s_cke;
    logic              s_ncs;
    logic              s_nras;
    logic              s_ncas;
    logic              s_nwe;
    logic [ba_w-1:0]   s_ba;
    logic [row_w-1:0]  s_a;
    logic [1:0]        s_dqm;
    wire  [data_w-1:0] s_db;
    logic              fault_en;
    logic [addr_w-1:0] fault_addr;
    int                refresh_count;
    logic              ref_late;
    logic              row_err;
    row_t              rows [n_rows];
    logic [31:0]       lcg_state;
    int                cycles;

    sdram_test dut0 (
        .S_CKE (s_cke), .S_NCS (s_ncs), .S_NRAS (s_nras), .S_NCAS (s_ncas),
        .S_NWE (s_nwe), .S_BA (s_ba), .S_A (s_a), .S_DQM (s_dqm), .S_DB (s_db),
        .*
    );

    sdram_model model0 (
        .clk (sys_clk), .cke (s_cke), .cs_n (s_ncs), .ras_n (s_nras), .cas_n (s_ncas),
        .we_n (s_nwe), .ba (s_ba), .a (s_a), .dqm (s_dqm), .dq (s_db),
        .*
    );

    initial sys_clk = 1'b0;
    always #10 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout waiting for done");
            $display("TB FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [addr_w-1:0] word_addr(int bank, int row, int col);
        return {bank[1:0], row[11:0], col[8:0]};
    endfunction

    // Untouched model contents
    function automatic logic [data_w-1:0] fill_word(logic [addr_w-1:0] a);
        return a[15:0] ^ {9'd0, a[22:16]};
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic load_row(input int i);
        @(posedge sys_clk);
        test_cfg.addr <= rows[i].addr;
        test_cfg.len  <= rows[i].len;
        pattern_base  <= rows[i].pat;
        start_n       <= 1'b0;
        if (rows[i].fault) begin  // Model corrupts the word only once
            fault_en   <= 1'b1;
            fault_addr <= rows[i].addr + addr_w'(rows[i].fault_k);
        end
    endtask

    task automatic check_memory(input int i);
        logic [addr_w-1:0] a;
        logic [data_w-1:0] exp_word;
        a = rows[i].addr;
        for (int k = 0; k < int'(rows[i].len); k++) begin
            exp_word = rows[i].pat + data_w'(k);  // Pattern wraps at 16 bits
            check(32'(model0.mem[a + addr_w'(k)]), 32'(exp_word), "model word");
        end
        if (a[col_w-1:0] != '0) begin
            check(32'(model0.mem[a - 1]), 32'(fill_word(a - 1)), "word before burst");
        end
        if (int'(a[col_w-1:0]) + int'(rows[i].len) < 512) begin
            a = a + addr_w'(rows[i].len);
            check(32'(model0.mem[a]), 32'(fill_word(a)), "word after burst");
        end
    endtask

    initial begin
        lcg_state = 32'hc39d_f69f;
        rows[0] = '{word_addr(0, 0, 0), 9'd256, 16'h0000, 1'b0, 9'd0, 9'd0};
        lcg_state = lcg_next(lcg_state);
        rows[1] = '{word_addr(1, 5, 3), 9'd1, lcg_state[31:16], 1'b0, 9'd0, 9'd0};
        lcg_state = lcg_next(lcg_state);
        rows[2] = '{word_addr(2, 100, 200), 9'd7, lcg_state[31:16], 1'b0, 9'd0, 9'd0};
        rows[3] = '{word_addr(3, 4095, 100), 9'd100, 16'h1234, 1'b0, 9'd0, 9'd0};
        rows[4] = '{word_addr(0, 7, 10), 9'd50, 16'hbeef, 1'b1, 9'd20, 9'd1};
        rows[5] = '{word_addr(1, 9, 0), 9'd256, 16'hfff0, 1'b0, 9'd0, 9'd0};  // Data wraps

        cycles       = 0;
        reset_n      = 1'b0;
        start_n      = 1'b1;
        test_cfg     = '0;
        pattern_base = '0;
        fault_en     = 1'b0;
        fault_addr   = '0;
        repeat (3) @(posedge sys_clk);
        reset_n <= 1'b1;

        @(negedge sys_clk);
        check(32'(s_cke), 32'd0, "cke during power-up");
        check(32'({s_nras, s_ncas, s_nwe}), 32'(nop), "command during power-up");
        while (!dut0.u_sdram_top.init_done) @(negedge sys_clk);
        check(32'(busy), 32'd0, "busy after init");
        check(32'(done), 32'd0, "done after init");
        check(32'(dut0.u_sdram_top.bus_oe), 32'd0, "bus driver after init");

        load_row(0);
        for (int i = 0; i < n_rows; i++) begin
            while (!busy) @(negedge sys_clk);
            check(32'(err_count), 32'd0, "err_count at start");
            if (i < n_rows - 1) begin
                load_row(i + 1);  // start_n stays low so the next run follows done
            end else begin
                @(posedge sys_clk);
                start_n <= 1'b1;
            end
            while (!done) @(negedge sys_clk);
            check(32'(err_count), 32'(rows[i].exp_err), "err_count at done");
            check_memory(i);
            @(negedge sys_clk);
            check(32'(done), 32'd0, "done pulse width");
        end

        check(32'(ref_late), 32'd0, "refresh interval flag");
        check(32'(row_err), 32'd0, "row access flag");
        check(32'(refresh_count > 2), 32'd1, "refresh seen after init");
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- tests/sdram_model.sv
`timescale 1ns/1ps

module sdram_model
    import sdram_cfg_pkg::*;
    import sdram_cmd_pkg::*;
(
    input  logic              clk,
    input  logic              cke,
    input  logic              cs_n,
    input  logic              ras_n,
    input  logic              cas_n,
    input  logic              we_n,
    input  logic [ba_w-1:0]   ba,
    input  logic [row_w-1:0]  a,
    input  logic [1:0]        dqm,         // High masks a byte lane on WRITE
    inout  wire  [data_w-1:0] dq,
    input  logic              fault_en,    // Flip bit 0 of fault_addr once on readback
    input  logic [addr_w-1:0] fault_addr,
    output int                refresh_count,
    output logic              ref_late,    // Refresh gap too long
    output logic              row_err      // Access to a closed bank or too early
);

    localparam int ref_limit = int'(refresh_interval) + int'(t_rfc) + 300;

    logic [data_w-1:0] mem [0:(1 << addr_w) - 1];
    logic [3:0]        open_bank;
    logic [11:0]       open_row [4];
    int                act_cyc [4];  // Cycle of last ACTIVE per bank
    int                cyc;
    int                since_ref;
    logic              seen_ref;
    logic              rd_v;         // READ seen last edge
    logic [addr_w-1:0] rd_a;
    logic              dq_oe;
    logic [data_w-1:0] dq_out;
    logic              fault_used;
    sdram_cmd_e        cmd;
    logic [addr_w-1:0] acc_addr;

    assign cmd      = sdram_cmd_e'({ras_n, cas_n, we_n});
    assign acc_addr = {ba, open_row[ba], a[col_w-1:0]};
    assign dq       = dq_oe ? dq_out : 'z;

    initial begin
        for (int i = 0; i < (1 << addr_w); i++) begin
            mem[i] = i[15:0] ^ {9'd0, i[22:16]};  // Fill depends on every address bit
        end
        open_bank     = '0;
        cyc           = 0;
        since_ref     = 0;
        seen_ref      = 1'b0;
        rd_v          = 1'b0;
        dq_oe         = 1'b0;
        fault_used    = 1'b0;
        refresh_count = 0;
        ref_late      = 1'b0;
        row_err       = 1'b0;
    end

    always @(posedge clk) begin
        cyc   <= cyc + 1;
        rd_v  <= 1'b0;
        dq_oe <= rd_v;  // Data on DQ during the second cycle after READ
        if (rd_v) begin
            dq_out <= mem[rd_a];
            if (fault_en && !fault_used && rd_a == fault_addr) begin
                dq_out     <= mem[rd_a] ^ 16'h0001;
                fault_used <= 1'b1;
            end
        end
        if (seen_ref) begin
            since_ref <= since_ref + 1;
        end
        if (seen_ref && since_ref > ref_limit) begin
            ref_late <= 1'b1;
        end
        if (cke && !cs_n) begin
            case (cmd)
                active: begin
                    if (open_bank[ba]) row_err <= 1'b1;  // Row already open
                    open_bank[ba] <= 1'b1;
                    open_row[ba]  <= a[11:0];
                    act_cyc[ba]   <= cyc;
                end
                write, read: begin
                    if (!open_bank[ba] || (cyc - act_cyc[ba]) < int'(t_rcd)) begin
                        row_err <= 1'b1;
                    end
                    if (cmd == write) begin
                        if (!dqm[0]) begin
                            mem[acc_addr][7:0] <= dq[7:0];
                        end
                        if (!dqm[1]) begin
                            mem[acc_addr][15:8] <= dq[15:8];
                        end
                    end else begin
                        rd_v <= 1'b1;
                        rd_a <= acc_addr;
                    end
                    if (a[10]) open_bank[ba] <= 1'b0;  // Auto-precharge
                end
                precharge: begin
                    if (a[10]) open_bank <= '0;
                    else open_bank[ba] <= 1'b0;
                end
                refresh: begin
                    if (open_bank != '0) row_err <= 1'b1;
                    refresh_count <= refresh_count + 1;
                    since_ref     <= 0;
                    seen_ref      <= 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/sdram_test.sv
`timescale 1ns/1ps

module sdram_test
    import sdram_cfg_pkg::*;
    import sdram_cmd_pkg::*;
(
    input  logic              sys_clk,
    input  logic              reset_n,
    input  logic              start_n,       // Low starts a run
    input  burst_req_t        test_cfg,      // Region under test
    input  logic [data_w-1:0] pattern_base,  // First data word
    output logic              busy,
    output logic              done,          // One cycle after last compare
    output logic [len_w-1:0]  err_count,     // Readback mismatches
    output logic              S_CKE,
    output logic              S_NCS,
    output logic              S_NRAS,
    output logic              S_NCAS,
    output logic              S_NWE,
    output logic [ba_w-1:0]   S_BA,
    output logic [row_w-1:0]  S_A,
    output logic [1:0]        S_DQM,
    inout  wire  [data_w-1:0] S_DB
);

    test_state_e       state;
    burst_req_t        cfg;        // Latched at start
    logic [len_w-1:0]  cnt;        // Words acked so far
    logic [data_w-1:0] wr_data;
    logic [data_w-1:0] exp_data;   // Same count as wr_data, for readback
    logic [data_w-1:0] rd_data;
    logic              wr_req;
    logic              rd_req;
    logic              wr_ack;
    logic              rd_ack;
    logic              init_done;
    logic              last_word;

    assign last_word = (cnt == cfg.len - 1'b1);

    always_ff @(posedge sys_clk) begin
        if (!reset_n) begin
            state     <= ts_idle;
            cnt       <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            wr_req    <= 1'b0;
            rd_req    <= 1'b0;
            err_count <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                ts_idle: begin
                    if (init_done && !start_n) begin
                        cfg       <= test_cfg;
                        wr_data   <= pattern_base;
                        exp_data  <= pattern_base;
                        err_count <= '0;          // Fresh count per run
                        cnt       <= '0;
                        busy      <= 1'b1;
                        wr_req    <= 1'b1;
                        state     <= ts_write;
                    end
                end

                ts_write: begin
                    if (wr_ack) begin
                        wr_req  <= 1'b0;          // Held only until the first ack
                        wr_data <= wr_data + 1'b1;
                        cnt     <= cnt + 1'b1;
                        if (last_word) begin
                            cnt    <= '0;
                            rd_req <= 1'b1;       // Read the same region back
                            state  <= ts_read;
                        end
                    end
                end

                ts_read: begin
                    if (rd_ack) begin
                        rd_req   <= 1'b0;
                        exp_data <= exp_data + 1'b1;
                        cnt      <= cnt + 1'b1;
                        if (rd_data != exp_data) begin
                            err_count <= err_count + 1'b1;
                        end
                        if (last_word) begin
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= ts_idle;
                        end
                    end
                end

                default: state <= ts_idle;
            endcase
        end
    end

    sdram_top u_sdram_top (
        .wr_burst (cfg),  // Write and read share one region
        .rd_burst (cfg),
        .*
    );

endmodule

//--- hdl/sdram_top.sv
`timescale 1ns/1ps

module sdram_top
    import sdram_cfg_pkg::*;
    import sdram_cmd_pkg::*;
(
    input  logic              sys_clk,
    input  logic              reset_n,
    input  logic              wr_req,
    input  logic              rd_req,
    input  burst_req_t        wr_burst,
    input  burst_req_t        rd_burst,
    input  logic [data_w-1:0] wr_data,
    output logic              wr_ack,
    output logic              rd_ack,
    output logic [data_w-1:0] rd_data,
    output logic              init_done,
    output logic              S_CKE,
    output logic              S_NCS,
    output logic              S_NRAS,
    output logic              S_NCAS,
    output logic              S_NWE,
    output logic [ba_w-1:0]   S_BA,
    output logic [row_w-1:0]  S_A,
    output logic [1:0]        S_DQM,
    inout  wire  [data_w-1:0] S_DB
);

    sdram_pins_t       init_pins;
    sdram_pins_t       ctrl_pins;
    logic              bus_oe;
    logic [data_w-1:0] wr_bus;

    sdram_init_seq u_init (.*);

    sdram_ctrl u_ctrl (
        .rd_bus (S_DB),  // Read back from the pad
        .*
    );

    // Init owns the pins until its mode load is done
    assign {S_CKE, S_NCS, S_NRAS, S_NCAS, S_NWE, S_BA, S_A} =
        init_done ? ctrl_pins : init_pins;

    assign S_DQM = 2'b00;                   // No byte masking
    assign S_DB  = bus_oe ? wr_bus : 'z;    // Released outside WRITE cycles

endmodule

//--- hdl/sdram_ctrl.sv
`timescale 1ns/1ps

module sdram_ctrl
    import sdram_cfg_pkg::*;
    import sdram_cmd_pkg::*;
(
    input  logic              sys_clk,
    input  logic              reset_n,
    input  logic              init_done,
    input  logic              wr_req,
    input  logic              rd_req,
    input  burst_req_t        wr_burst,
    input  burst_req_t        rd_burst,
    input  logic [data_w-1:0] wr_data,
    input  logic [data_w-1:0] rd_bus,
    output logic              wr_ack,
    output logic              rd_ack,
    output logic [data_w-1:0] rd_data,
    output sdram_pins_t       ctrl_pins,
    output logic              bus_oe,
    output logic [data_w-1:0] wr_bus
);

    ctrl_state_e        state;
    burst_req_t         req;      // Selected request with read first
    burst_req_t         cur;      // Burst in progress
    logic               cur_rd;   // Burst in progress is a read
    logic [len_w-1:0]   cnt;      // Wait cycles or words left
    logic [col_w-1:0]   col;      // Next column
    logic [11:0]        ref_cnt;  // Free-running refresh timer
    logic               ref_pend;
    logic [cas_lat-1:0] rd_pipe;  // READs still in flight
    logic               rd_issue;
    logic [ba_w-1:0]    ba;
    logic               last;     // Final word sets A10 for auto-precharge

    assign req      = rd_req ? rd_burst : wr_burst;
    assign ba       = cur.addr[addr_w-1 -: ba_w];
    assign last     = (cnt == '0);
    assign rd_issue = ({ctrl_pins.ras_n, ctrl_pins.cas_n, ctrl_pins.we_n} == read);

    always_ff @(posedge sys_clk) begin
        if (!reset_n) begin
            state     <= c_idle;
            cnt       <= '0;
            ref_cnt   <= '0;
            ref_pend  <= 1'b0;
            wr_ack    <= 1'b0;
            rd_ack    <= 1'b0;
            bus_oe    <= 1'b0;
            rd_pipe   <= '0;
            ctrl_pins <= mk_pins(nop, '0, '0);
        end else begin
            ctrl_pins <= mk_pins(nop, ba, '0);
            bus_oe    <= 1'b0;                             // Bus released unless writing
            rd_pipe   <= {rd_pipe[cas_lat-2:0], rd_issue};
            rd_ack    <= rd_pipe[cas_lat-1];               // Word sampled into rd_data now
            ref_cnt   <= ref_cnt + 12'd1;
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end

            case (state)
                c_idle: begin
                    if (init_done && ref_pend) begin       // Refresh goes first
                        ctrl_pins <= mk_pins(refresh, '0, '0);
                        ref_pend  <= 1'b0;
                        cnt       <= len_w'(t_rfc - 4'd1);
                        state     <= c_refresh;
                    end else if (init_done && (rd_req || wr_req)) begin
                        ctrl_pins <= mk_pins(active, req.addr[addr_w-1 -: ba_w],
                                             {1'b0, req.addr[addr_w-ba_w-1:col_w]});
                        cur       <= req;
                        cur_rd    <= rd_req;
                        col       <= req.addr[col_w-1:0];
                        // READ lands t_rcd after ACTIVE and WRITE one later
                        cnt       <= rd_req ? len_w'(t_rcd - 4'd2) : len_w'(t_rcd - 4'd1);
                        state     <= c_rcd;
                    end
                end

                c_refresh: begin
                    if (cnt == '0) begin
                        state <= c_idle;
                    end
                end

                c_rcd: begin
                    if (cnt == '0) begin
                        cnt    <= cur.len - 1'b1;
                        wr_ack <= !cur_rd;                 // Ack only write bursts
                        state  <= cur_rd ? c_read : c_write;
                    end
                end

                c_write: begin
                    ctrl_pins <= mk_pins(write, ba, {2'b00, last, 1'b0, col});
                    bus_oe    <= 1'b1;                     // Drive DQ with the WRITE
                    wr_bus    <= wr_data;
                    col       <= col + 1'b1;
                    if (last) begin
                        wr_ack <= 1'b0;
                        cnt    <= len_w'(t_wr) + len_w'(t_rp);  // Write recovery then precharge
                        state  <= c_rec;
                    end
                end

                c_read: begin
                    ctrl_pins <= mk_pins(read, ba, {2'b00, last, 1'b0, col});
                    col       <= col + 1'b1;
                    if (last) begin
                        cnt   <= len_w'(cas_lat) + len_w'(t_rp);
                        state <= c_rec;
                    end
                end

                c_rec: begin
                    if (cnt == '0) begin
                        state <= c_idle;                   // Bank closed again
                    end
                end

                default: state <= c_idle;
            endcase

            if (ref_cnt == refresh_interval - 12'd1) begin
                ref_cnt  <= '0;
                ref_pend <= 1'b1;                          // Served at next idle
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        rd_data <= rd_bus;                                 // Registered DQ
    end

endmodule

//--- hdl/sdram_init_seq.sv
`timescale 1ns/1ps

module sdram_init_seq
    import sdram_cfg_pkg::*;
    import sdram_cmd_pkg::*;
(
    input  logic        sys_clk,
    input  logic        reset_n,
    output sdram_pins_t init_pins,
    output logic        init_done
);

    // Each step issues its command once the previous wait has run out
    typedef enum logic [2:0] {
        i_pwr,   // Power-up wait, cke low
        i_pre,   // After precharge-all
        i_ref1,  // After first refresh
        i_ref2,  // After second refresh
        i_mrs,   // After mode load
        i_done
    } init_state_e;

    init_state_e state;
    logic [15:0] cnt;  // Remaining wait cycles

    always_ff @(posedge sys_clk) begin
        if (!reset_n) begin
            state         <= i_pwr;
            cnt           <= t_powerup - 16'd1;
            init_pins     <= mk_pins(nop, '0, '0);
            init_pins.cke <= 1'b0;                       // Held low until first command
            init_done     <= 1'b0;
        end else begin
            init_pins     <= mk_pins(nop, '0, '0);
            init_pins.cke <= (state != i_pwr);
            if (cnt != 16'd0) begin
                cnt <= cnt - 16'd1;
            end else begin
                case (state)
                    i_pwr: begin
                        init_pins <= mk_pins(precharge, '0, 13'h0400);  // A10 selects all banks
                        cnt       <= 16'(t_rp);
                        state     <= i_pre;
                    end
                    i_pre, i_ref1: begin
                        init_pins <= mk_pins(refresh, '0, '0);
                        cnt       <= 16'(t_rfc);
                        state     <= (state == i_pre) ? i_ref1 : i_ref2;
                    end
                    i_ref2: begin
                        init_pins <= mk_pins(load_mode, '0, mode_word);
                        cnt       <= 16'(t_mrd);
                        state     <= i_mrs;
                    end
                    i_mrs: begin
                        init_done <= 1'b1;               // Stays set until reset
                        state     <= i_done;
                    end
                    default: state <= i_done;
                endcase
            end
        end
    end

endmodule

//--- hdl/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

    import sdram_cfg_pkg::*;

    // Encoded as {ras_n, cas_n, we_n}
    typedef enum logic [2:0] {
        nop        = 3'b111,
        active     = 3'b011,
        read       = 3'b101,
        write      = 3'b100,
        burst_term = 3'b110,
        precharge  = 3'b010,
        refresh    = 3'b001,
        load_mode  = 3'b000
    } sdram_cmd_e;

    typedef enum logic [3:0] {
        c_idle,     // Waits for init, refresh or a request
        c_refresh,  // Refresh in progress
        c_rcd,      // Row activated, waiting t_rcd
        c_write,    // One WRITE per cycle
        c_read,     // One READ per cycle
        c_rec       // Auto-precharge recovery
    } ctrl_state_e;

    typedef enum logic [2:0] {
        ts_idle,
        ts_write,
        ts_read
    } test_state_e;

    typedef struct packed {
        logic             cke;
        logic             cs_n;
        logic             ras_n;
        logic             cas_n;
        logic             we_n;
        logic [ba_w-1:0]  ba;
        logic [row_w-1:0] addr;
    } sdram_pins_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;  // Start word
        logic [len_w-1:0]  len;   // 1 to 256 words, same row
    } burst_req_t;

    // Selected chip with clock enabled
    function automatic sdram_pins_t mk_pins(sdram_cmd_e cmd, logic [ba_w-1:0] ba,
                                            logic [row_w-1:0] addr);
        sdram_pins_t p;
        p.cke  = 1'b1;
        p.cs_n = 1'b0;
        {p.ras_n, p.cas_n, p.we_n} = cmd;
        p.ba   = ba;
        p.addr = addr;
        return p;
    endfunction

endpackage

//--- hdl/sdram_cfg_pkg.sv
package sdram_cfg_pkg;

    // Geometry, word address is {bank, row[11:0], column}
    localparam int addr_w = 23;  // Word address
    localparam int data_w = 16;  // DQ width
    localparam int col_w  = 9;   // Column bits
    localparam int row_w  = 13;  // Row bits, also the A bus width
    localparam int ba_w   = 2;   // Four banks
    localparam int len_w  = 9;   // Burst length up to 256

    // Waits in sys_clk cycles at a 20 ns period
    localparam logic [15:0] t_powerup = 16'd10000;  // 200 us after power-up
    localparam logic [3:0]  t_rp      = 4'd2;       // Precharge to activate
    localparam logic [3:0]  t_rcd     = 4'd2;       // Activate to read or write
    localparam logic [3:0]  t_rfc     = 4'd4;       // Refresh cycle time
    localparam logic [3:0]  t_mrd     = 4'd2;       // Mode load to first command
    localparam logic [3:0]  t_wr      = 4'd2;       // Write recovery before precharge

    localparam int cas_lat = 2;  // Read data lands two cycles after READ

    // 8192 rows in 64 ms gives one refresh per 7.8 us
    localparam logic [11:0] refresh_interval = 12'd390;

    // Mode register fields
    localparam logic [12:0] mode_word = {
        3'b000,  // Reserved
        1'b1,    // Single access writes
        2'b00,   // Standard operation
        3'b010,  // CAS latency 2
        1'b0,    // Sequential
        3'b000   // Burst length 1
    };

endpackage
